// File: inverter_link_pkg.sv
// Inverter link shared types
`default_nettype none

package inverter_link_pkg;

    // Sample view of an SPI word
    typedef struct packed {
        logic [11:0] sin_index;
        logic [3:0]  module_id;
    } sample_t;

    // Command view of the same word
    typedef struct packed {
        logic [11:0] opcode;
        logic [3:0]  tag;
    } command_t;

    // One 16-bit SPI word, decoded as either a sample or a command
    typedef union packed {
        sample_t  sample;
        command_t command;
    } spi_word_t;

    // Pipe-mode command, both fields must match
    localparam logic [11:0] PIPE_OPCODE = 12'hF0F;
    localparam logic [3:0]  PIPE_TAG    = 4'hA;

    // Byte broadcast from the sequencer to every lane
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } lane_byte_t;

    // SPI master outputs
    typedef struct packed {
        logic sclk;
        logic cs_n;
    } spi_pins_t;

endpackage

`default_nettype wire

// File: spi_sample_reader.sv
// SPI word reader
`default_nettype none

module spi_sample_reader #(
    parameter int SCLK_DIV = 2
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         read_req,
    input  wire logic                         miso,
    output inverter_link_pkg::spi_pins_t      pins,
    output inverter_link_pkg::spi_word_t      word,
    output logic                              word_valid
);

    localparam int DIV_W = $clog2(SCLK_DIV + 1);

    logic             busy;
    logic             sclk;
    logic             cs_n;
    logic             deliver;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       half_cnt;
    logic [15:0]      shift_reg;
    logic             half_done;

    // End of one sclk half period
    assign half_done = (div_cnt == DIV_W'(SCLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            sclk       <= 1'b0;
            cs_n       <= 1'b1;
            deliver    <= 1'b0;
            div_cnt    <= '0;
            half_cnt   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= deliver;
            deliver    <= 1'b0;
            if (!busy) begin
                if (read_req) begin
                    busy     <= 1'b1;
                    cs_n     <= 1'b0;
                    div_cnt  <= '0;
                    half_cnt <= '0;
                end
            end else if (half_done) begin
                div_cnt  <= '0;
                half_cnt <= half_cnt + 5'd1;
                if (half_cnt == 5'd31) begin
                    // Last falling edge, release the slave
                    busy    <= 1'b0;
                    sclk    <= 1'b0;
                    cs_n    <= 1'b1;
                    deliver <= 1'b1;
                end else begin
                    sclk <= ~sclk;
                end
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
        end
    end

    // MSB first, captured as sclk rises
    always_ff @(posedge clk) begin
        if (busy && half_done && !sclk) begin
            shift_reg <= {shift_reg[14:0], miso};
        end
    end

    assign word = shift_reg;
    assign pins = '{sclk: sclk, cs_n: cs_n};

    // Word is only handed over after the slave is deselected
    a_valid_after_cs: assert property (
        @(posedge clk) disable iff (reset) word_valid |-> pins.cs_n
    );

endmodule

`default_nettype wire

// File: frame_timer.sv
// Startup hold-off and frame tick
`default_nettype none

module frame_timer #(
    parameter int STARTUP_CYCLES = 300,
    parameter int FRAME_CYCLES   = 200
) (
    input  wire logic clk,
    input  wire logic reset,
    output logic      frame_tick
);

    localparam int START_W = $clog2(STARTUP_CYCLES + 1);
    localparam int FRAME_W = $clog2(FRAME_CYCLES + 1);

    logic               running;
    logic [START_W-1:0] startup_cnt;
    logic [FRAME_W-1:0] period_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            running     <= 1'b0;
            startup_cnt <= '0;
            period_cnt  <= '0;
            frame_tick  <= 1'b0;
        end else if (!running) begin
            // First tick marks the end of the hold-off
            frame_tick <= (startup_cnt == START_W'(STARTUP_CYCLES - 1));
            if (startup_cnt == START_W'(STARTUP_CYCLES - 1)) begin
                running    <= 1'b1;
                period_cnt <= '0;
            end else begin
                startup_cnt <= startup_cnt + START_W'(1);
            end
        end else begin
            frame_tick <= (period_cnt == FRAME_W'(FRAME_CYCLES - 1));
            if (period_cnt == FRAME_W'(FRAME_CYCLES - 1)) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + FRAME_W'(1);
            end
        end
    end

    // No tick until the hold-off count has run out
    a_no_tick_in_holdoff: assert property (
        @(posedge clk) disable iff (reset)
            frame_tick |-> startup_cnt == START_W'(STARTUP_CYCLES - 1)
    );

endmodule

`default_nettype wire

// File: uart_tx.sv
// UART transmit lane
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 4
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire inverter_link_pkg::lane_byte_t in_byte,
    output logic                              tx,
    output logic                              credit_return
);

    localparam int BIT_W = $clog2(CLKS_PER_BIT + 1);

    logic             buf_full;
    logic [7:0]       buf_data;
    logic             busy;
    logic [10:0]      frame_sr;
    logic [3:0]       bit_cnt;
    logic [BIT_W-1:0] bit_timer;
    logic             bit_end;
    logic             frame_end;
    logic             load;

    assign bit_end   = (bit_timer == BIT_W'(CLKS_PER_BIT - 1));
    assign frame_end = busy && bit_end && (bit_cnt == 4'd10);
    // Move the buffered byte into the shifter when it is free
    assign load      = buf_full && (!busy || frame_end);

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_full      <= 1'b0;
            busy          <= 1'b0;
            bit_cnt       <= '0;
            bit_timer     <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= frame_end;
            if (in_byte.valid) begin
                buf_full <= 1'b1;
            end else if (load) begin
                buf_full <= 1'b0;
            end
            if (load) begin
                busy      <= 1'b1;
                bit_cnt   <= '0;
                bit_timer <= '0;
            end else if (busy) begin
                if (bit_end) begin
                    bit_timer <= '0;
                    if (bit_cnt == 4'd10) begin
                        busy <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end else begin
                    bit_timer <= bit_timer + BIT_W'(1);
                end
            end
        end
    end

    // Stop, even parity, data LSB first, start
    always_ff @(posedge clk) begin
        if (in_byte.valid) begin
            buf_data <= in_byte.data;
        end
        if (load) begin
            frame_sr <= {1'b1, ^buf_data, buf_data, 1'b0};
        end else if (busy && bit_end) begin
            frame_sr <= {1'b1, frame_sr[10:1]};
        end
    end

    // Line idles high
    assign tx = busy ? frame_sr[0] : 1'b1;

    // Sender must hold off until its credit comes back
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (reset) in_byte.valid |-> !buf_full
    );

endmodule

`default_nettype wire

// File: link_sequencer.sv
// Frame sequencer for the module lanes
`default_nettype none

module link_sequencer #(
    parameter int NUM_LANES = 3
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire inverter_link_pkg::spi_word_t word,
    input  wire logic                         word_valid,
    input  wire logic                         frame_tick,
    input  wire logic [NUM_LANES-1:0]         credit_return,
    output logic                              read_req,
    output inverter_link_pkg::lane_byte_t     lane_out,
    output logic                              shoot,
    output logic                              pipe_mode,
    output logic                              overrun
);

    import inverter_link_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_WORD,
        S_SEND0,
        S_SEND1,
        S_DRAIN,
        S_WAIT_TICK,
        S_PIPE
    } state_t;

    state_t               state;
    sample_t              sample_q;
    logic [NUM_LANES-1:0] credit;
    logic                 all_credits;
    logic                 send;
    logic                 is_pipe;
    logic                 in_frame;

    assign all_credits = &credit;
    assign send        = ((state == S_SEND0) || (state == S_SEND1)) && all_credits;
    assign is_pipe     = (word.command.opcode == PIPE_OPCODE) &&
                         (word.command.tag == PIPE_TAG);
    // Steps that must finish before the next tick
    assign in_frame    = (state == S_WAIT_WORD) || (state == S_SEND0) ||
                         (state == S_SEND1) || (state == S_DRAIN);

    // One credit per lane, taken on send and given back by the lane
    always_ff @(posedge clk) begin
        if (reset) begin
            credit <= '1;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (send) begin
                    credit[i] <= 1'b0;
                end else if (credit_return[i]) begin
                    credit[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= S_IDLE;
            read_req       <= 1'b0;
            lane_out.valid <= 1'b0;
            shoot          <= 1'b0;
            pipe_mode      <= 1'b0;
            overrun        <= 1'b0;
        end else begin
            read_req       <= 1'b0;
            lane_out.valid <= 1'b0;
            shoot          <= 1'b0;
            if (frame_tick && in_frame) begin
                overrun <= 1'b1;
            end
            // Byte payload
            if (state == S_SEND0) begin
                lane_out.data <= sample_q.sin_index[11:4];
            end else if (state == S_SEND1) begin
                lane_out.data <= {sample_q.sin_index[3:0], sample_q.module_id};
            end
            case (state)
                S_IDLE: begin
                    if (frame_tick) begin
                        read_req <= 1'b1;
                        state    <= S_WAIT_WORD;
                    end
                end
                S_WAIT_WORD: begin
                    if (word_valid) begin
                        if (is_pipe) begin
                            pipe_mode <= 1'b1;
                            state     <= S_PIPE;
                        end else begin
                            state <= S_SEND0;
                        end
                    end
                end
                S_SEND0: begin
                    if (all_credits) begin
                        lane_out.valid <= 1'b1;
                        state          <= S_SEND1;
                    end
                end
                S_SEND1: begin
                    if (all_credits) begin
                        lane_out.valid <= 1'b1;
                        state          <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (all_credits) begin
                        state <= S_WAIT_TICK;
                    end
                end
                S_WAIT_TICK: begin
                    // Fire all modules and start the next frame together
                    if (frame_tick) begin
                        shoot    <= 1'b1;
                        read_req <= 1'b1;
                        state    <= S_WAIT_WORD;
                    end
                end
                S_PIPE: begin
                    state <= S_PIPE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Sample held for the byte split
    always_ff @(posedge clk) begin
        if (state == S_WAIT_WORD && word_valid) begin
            sample_q <= word.sample;
        end
    end

    // No module fires while a byte is going out or still on a lane
    a_shoot_not_with_byte: assert property (
        @(posedge clk) disable iff (reset) shoot |-> !lane_out.valid && all_credits
    );

endmodule

`default_nettype wire

// File: inverter_link_top.sv
// Inverter link control core
`default_nettype none

module inverter_link_top #(
    parameter int NUM_LANES      = 3,
    parameter int CLKS_PER_BIT   = 4,
    parameter int SCLK_DIV       = 2,
    parameter int STARTUP_CYCLES = 300,
    parameter int FRAME_CYCLES   = 200
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    miso,
    output inverter_link_pkg::spi_pins_t spi,
    output logic [NUM_LANES-1:0]         tx,
    output logic                         shoot,
    output logic                         pipe_mode,
    output logic                         overrun
);

    import inverter_link_pkg::*;

    spi_word_t            word;
    logic                 word_valid;
    logic                 read_req;
    logic                 frame_tick;
    lane_byte_t           lane_bus;
    logic [NUM_LANES-1:0] credit_return;

    spi_sample_reader #(
        .SCLK_DIV(SCLK_DIV)
    ) u_reader (
        .clk       (clk),
        .reset     (reset),
        .read_req  (read_req),
        .miso      (miso),
        .pins      (spi),
        .word      (word),
        .word_valid(word_valid)
    );

    frame_timer #(
        .STARTUP_CYCLES(STARTUP_CYCLES),
        .FRAME_CYCLES  (FRAME_CYCLES)
    ) u_timer (
        .clk       (clk),
        .reset     (reset),
        .frame_tick(frame_tick)
    );

    link_sequencer #(
        .NUM_LANES(NUM_LANES)
    ) u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .word         (word),
        .word_valid   (word_valid),
        .frame_tick   (frame_tick),
        .credit_return(credit_return),
        .read_req     (read_req),
        .lane_out     (lane_bus),
        .shoot        (shoot),
        .pipe_mode    (pipe_mode),
        .overrun      (overrun)
    );

    // One transmitter per power module
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        uart_tx #(
            .CLKS_PER_BIT(CLKS_PER_BIT)
        ) u_tx (
            .clk          (clk),
            .reset        (reset),
            .in_byte      (lane_bus),
            .tx           (tx[i]),
            .credit_return(credit_return[i])
        );
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock source
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tb_uart_monitor.sv
// UART lane decoder
`default_nettype none

module tb_uart_monitor #(
    parameter int CLKS_PER_BIT = 4,
    parameter int LANE         = 0
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic tx,
    output logic       byte_strobe,
    output logic [7:0] byte_data,
    output int         error_count
);

    logic        active;
    int          cnt;
    int          errs;
    logic [10:0] bits;

    assign error_count = errs;

    // Line is sampled as it was just before each clock edge
    always @(posedge clk) begin
        byte_strobe <= 1'b0;
        if (reset) begin
            active = 1'b0;
            cnt    = 0;
            errs   = 0;
            bits   = '1;
        end else begin
            if (!active) begin
                if (!tx) begin
                    // Falling edge of the start bit
                    active = 1'b1;
                    cnt    = 0;
                end
            end else begin
                cnt++;
            end
            if (active) begin
                // Mid-bit sample
                if (cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                    bits[cnt / CLKS_PER_BIT] = tx;
                end
                // A new start bit must not cut the stop bit short
                if (cnt >= 10 * CLKS_PER_BIT && !tx) begin
                    $display("Lane %0d line went low during the stop bit at %0t", LANE, $time);
                    errs++;
                end
                if (cnt == 11 * CLKS_PER_BIT - 1) begin
                    if (bits[0] != 1'b0) begin
                        $display("ERR %0t lane%0d start got %b expected 0", $time, LANE, bits[0]);
                        errs++;
                    end
                    if (bits[9] != ^bits[8:1]) begin
                        $display("ERR %0t lane%0d parity got %b expected %b",
                                 $time, LANE, bits[9], ^bits[8:1]);
                        errs++;
                    end
                    if (bits[10] != 1'b1) begin
                        $display("ERR %0t lane%0d stop got %b expected 1", $time, LANE, bits[10]);
                        errs++;
                    end
                    byte_data   <= bits[8:1];
                    byte_strobe <= 1'b1;
                    active = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_inverter_link.sv
// Inverter link testbench
`default_nettype none

module tb_inverter_link;

    import inverter_link_pkg::*;

    localparam int NUM_LANES      = 3;
    localparam int CLKS_PER_BIT   = 4;
    localparam int SCLK_DIV       = 2;
    localparam int STARTUP_CYCLES = 300;
    localparam int FRAME_CYCLES   = 200;
    localparam int NUM_SAMPLES    = 20;
    localparam int DRIVE_DELAY    = 5;
    localparam int QUIET_CYCLES   = 2 * FRAME_CYCLES;
    localparam int TIMEOUT_CYCLES = STARTUP_CYCLES + (NUM_SAMPLES + 2) * FRAME_CYCLES + 1000;

    logic                 clk;
    logic                 reset;
    logic                 miso;
    spi_pins_t            spi;
    logic [NUM_LANES-1:0] tx;
    logic                 shoot;
    logic                 pipe_mode;
    logic                 overrun;

    logic [NUM_LANES-1:0] rx_strobe;
    logic [7:0]           rx_data [NUM_LANES];
    int                   mon_errors [NUM_LANES];
    int                   rx_count [NUM_LANES];

    logic [15:0] words [NUM_SAMPLES + 1];
    logic [15:0] cur_word;
    logic [7:0]  exp_byte;
    logic        prev_cs_n;
    logic        prev_sclk;
    logic        shoot_prev;
    logic        overrun_seen;
    int          bit_idx;
    int          served;
    int          since_reset;
    int          errors;
    int          shoot_count;
    int          last_shoot;
    int          lane_i;
    int          cycle_count = 0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Byte n of a sample as every lane should receive it
    function automatic logic [7:0] lane_byte(input logic [15:0] w, input int n);
        logic [11:0] sin_index;
        logic [3:0]  module_id;
        sin_index = w[15:4];
        module_id = w[3:0];
        if (n == 0) begin
            return sin_index[11:4];
        end else begin
            return {sin_index[3:0], module_id};
        end
    endfunction

    task automatic make_words();
        logic [31:0] state;
        int          k;
        state = 32'h4e32_429d;
        for (k = 0; k < NUM_SAMPLES; k++) begin
            state = xorshift32(state);
            // A sample must never alias the pipe command
            while (state[15:0] == {PIPE_OPCODE, PIPE_TAG}) begin
                state = xorshift32(state);
            end
            words[k] = state[15:0];
        end
        words[NUM_SAMPLES] = {PIPE_OPCODE, PIPE_TAG};
    endtask

    tb_clock_gen #(
        .PERIOD(40)
    ) clock0 (
        .clk(clk)
    );

    inverter_link_top #(
        .NUM_LANES     (NUM_LANES),
        .CLKS_PER_BIT  (CLKS_PER_BIT),
        .SCLK_DIV      (SCLK_DIV),
        .STARTUP_CYCLES(STARTUP_CYCLES),
        .FRAME_CYCLES  (FRAME_CYCLES)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .miso     (miso),
        .spi      (spi),
        .tx       (tx),
        .shoot    (shoot),
        .pipe_mode(pipe_mode),
        .overrun  (overrun)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_mon
        tb_uart_monitor #(
            .CLKS_PER_BIT(CLKS_PER_BIT),
            .LANE        (i)
        ) u_mon (
            .clk        (clk),
            .reset      (reset),
            .tx         (tx[i]),
            .byte_strobe(rx_strobe[i]),
            .byte_data  (rx_data[i]),
            .error_count(mon_errors[i])
        );
    end

    // SPI slave, next bit goes out after each falling sclk
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (!reset && prev_cs_n && !spi.cs_n) begin
            if (served > NUM_SAMPLES) begin
                $display("SPI read %0d at %0t came after the pipe command", served + 1, $time);
                errors++;
                cur_word = 16'hFFFF;
            end else begin
                cur_word = words[served];
            end
            served++;
            bit_idx = 15;
            miso    = cur_word[15];
        end else if (!spi.cs_n && prev_sclk && !spi.sclk && bit_idx > 0) begin
            bit_idx--;
            miso = cur_word[bit_idx];
        end
        prev_cs_n = spi.cs_n;
        prev_sclk = spi.sclk;
    end

    // Lane bytes, shoot pulses and mode flags
    always @(posedge clk) begin
        if (reset) begin
            since_reset = 0;
        end else begin
            since_reset++;
            if (since_reset <= STARTUP_CYCLES && (!spi.cs_n || tx != '1 || shoot)) begin
                $display("Frame traffic at %0t before the startup hold-off ended", $time);
                errors++;
            end
            for (lane_i = 0; lane_i < NUM_LANES; lane_i++) begin
                if (rx_strobe[lane_i]) begin
                    if (rx_count[lane_i] >= 2 * NUM_SAMPLES) begin
                        $display("Lane %0d received an extra byte at %0t", lane_i, $time);
                        errors++;
                    end else begin
                        exp_byte = lane_byte(words[rx_count[lane_i] / 2], rx_count[lane_i] % 2);
                        if (rx_data[lane_i] != exp_byte) begin
                            $display("ERR %0t lane%0d byte got %h expected %h",
                                     $time, lane_i, rx_data[lane_i], exp_byte);
                            errors++;
                        end
                    end
                    rx_count[lane_i]++;
                end
            end
            if (shoot) begin
                if (shoot_prev) begin
                    $display("Shoot pulse at %0t is wider than one cycle", $time);
                    errors++;
                end
                for (lane_i = 0; lane_i < NUM_LANES; lane_i++) begin
                    if (rx_count[lane_i] != 2 * (shoot_count + 1)) begin
                        $display("ERR %0t lane%0d bytes_before_shoot got %0d expected %0d",
                                 $time, lane_i, rx_count[lane_i], 2 * (shoot_count + 1));
                        errors++;
                    end
                end
                if (shoot_count > 0 && since_reset - last_shoot != FRAME_CYCLES) begin
                    $display("ERR %0t shoot_interval got %0d expected %0d",
                             $time, since_reset - last_shoot, FRAME_CYCLES);
                    errors++;
                end
                if (pipe_mode) begin
                    $display("Shoot pulse at %0t came after pipe mode was entered", $time);
                    errors++;
                end
                last_shoot = since_reset;
                shoot_count++;
            end
            shoot_prev = shoot;
            if (pipe_mode && tx != '1) begin
                $display("UART traffic at %0t after pipe mode was entered", $time);
                errors++;
            end
            if (pipe_mode && served < NUM_SAMPLES + 1) begin
                $display("Pipe mode at %0t before the pipe command was served", $time);
                errors++;
            end
            if (overrun && !overrun_seen) begin
                $display("ERR %0t overrun got 1 expected 0", $time);
                errors++;
                overrun_seen = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, the run did not reach pipe mode", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int lane;
        int mon_sum;
        reset        = 1'b1;
        miso         = 1'b1;
        prev_cs_n    = 1'b1;
        prev_sclk    = 1'b0;
        shoot_prev   = 1'b0;
        overrun_seen = 1'b0;
        cur_word     = '0;
        bit_idx      = 0;
        served       = 0;
        errors       = 0;
        shoot_count  = 0;
        last_shoot   = 0;
        since_reset  = 0;
        for (lane = 0; lane < NUM_LANES; lane++) begin
            rx_count[lane] = 0;
        end
        make_words();
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        // Idle levels straight after reset
        if (tx != '1) begin
            $display("ERR %0t tx got %b expected %b", $time, tx, {NUM_LANES{1'b1}});
            errors++;
        end
        if (spi.cs_n != 1'b1) begin
            $display("ERR %0t cs_n got %b expected 1", $time, spi.cs_n);
            errors++;
        end
        if (shoot || pipe_mode || overrun) begin
            $display("ERR %0t shoot/pipe_mode/overrun got %b%b%b expected 000",
                     $time, shoot, pipe_mode, overrun);
            errors++;
        end
        while (!pipe_mode) begin
            @(posedge clk);
        end
        // Watch for stray traffic once the link has stopped
        repeat (QUIET_CYCLES) @(posedge clk);
        if (shoot_count != NUM_SAMPLES) begin
            $display("ERR %0t shoot_count got %0d expected %0d", $time, shoot_count, NUM_SAMPLES);
            errors++;
        end
        if (served != NUM_SAMPLES + 1) begin
            $display("ERR %0t spi_reads got %0d expected %0d", $time, served, NUM_SAMPLES + 1);
            errors++;
        end
        mon_sum = 0;
        for (lane = 0; lane < NUM_LANES; lane++) begin
            if (rx_count[lane] != 2 * NUM_SAMPLES) begin
                $display("ERR %0t lane%0d byte_count got %0d expected %0d",
                         $time, lane, rx_count[lane], 2 * NUM_SAMPLES);
                errors++;
            end
            mon_sum += mon_errors[lane];
        end
        $display("Errors: %0d from checks, %0d from UART monitors", errors, mon_sum);
        if (errors + mon_sum == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
inverter_link_pkg.sv
spi_sample_reader.sv
frame_timer.sv
uart_tx.sv
link_sequencer.sv
inverter_link_top.sv
tb_clock_gen.sv
tb_uart_monitor.sv
tb_inverter_link.sv

// File: Makefile
TOP = tb_inverter_link
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "All checks passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir $(LOG)
